/* reg_map_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Router statistics register map
////////////////////////////////////////////////////////////////////////////

package reg_map_pkg;

    // Word address and register word
    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    ////////////////////////////////////////////////////////////////////////////
    // Register addresses
    ////////////////////////////////////////////////////////////////////////////

    localparam reg_addr_t ADDR_VERSION_ID       = 8'd0;
    localparam reg_addr_t ADDR_NUM_REGS         = 8'd1;
    localparam reg_addr_t ADDR_PORT_ENABLE_CON  = 8'd2;
    localparam reg_addr_t ADDR_PORT_ENABLE_STAT = 8'd3;
    localparam reg_addr_t ADDR_COUNTER_CON      = 8'd4;
    localparam reg_addr_t ADDR_COUNTERS_START   = 8'd5;

    // pkt, bytes, err and drop per port
    localparam int COUNTER_SLOTS_PER_PORT = 4;

    // Version 1.0 in the upper half, ID 10 in the lower half
    localparam reg_data_t MODULE_VERSION_ID = {8'd1, 8'd0, 16'd10};

    ////////////////////////////////////////////////////////////////////////////
    // Register port
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic      wr;
        logic      rd;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

    typedef struct packed {
        logic      rd_valid;
        logic      rd_error;
        reg_data_t rd_data;
    } reg_rsp_t;

endpackage

/* port_stats_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Port traffic statistics types
////////////////////////////////////////////////////////////////////////////

package port_stats_pkg;

    typedef logic [31:0] count_t;

    // Counts delivered by the traffic path for one port
    typedef struct packed {
        count_t pkt;
        count_t bytes;
        count_t err;
    } port_counts_t;

    // Slot order within a port's block of counter registers
    typedef enum logic [1:0] {
        SLOT_PKT   = 2'd0,
        SLOT_BYTES = 2'd1,
        SLOT_ERR   = 2'd2,
        SLOT_DROP  = 2'd3
    } counter_slot_e;

endpackage

/* reg_decode.sv */
////////////////////////////////////////////////////////////////////////////
// Register request decode
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reg_decode #(
    parameter int NUM_PORTS = 8
) (
    input  logic                  clk_ifc,
    input  logic                  peripheral_sresetn_core,

    input  reg_map_pkg::reg_req_t bus_req,

    // Write side, same cycle as the strobe
    output logic                  wr_enable_con,
    output logic                  wr_counter_con,
    output reg_map_pkg::reg_data_t wdata,

    // Read side, one cycle after the strobe
    output logic                  rd_pending,
    output logic                  rd_error,
    output reg_map_pkg::reg_addr_t rd_addr
);

    // Identification and control words, then four counters per port
    localparam reg_map_pkg::reg_addr_t NUM_REGS = reg_map_pkg::reg_addr_t'(
        reg_map_pkg::ADDR_COUNTERS_START + reg_map_pkg::COUNTER_SLOTS_PER_PORT * NUM_PORTS);

    logic rd_out_of_range;

    ////////////////////////////////////////////////////////////////////////////
    // Writes
    ////////////////////////////////////////////////////////////////////////////

    // Only the two control registers accept writes
    always_comb begin
        wr_enable_con  = bus_req.wr && (bus_req.addr == reg_map_pkg::ADDR_PORT_ENABLE_CON);
        wr_counter_con = bus_req.wr && (bus_req.addr == reg_map_pkg::ADDR_COUNTER_CON);
    end

    assign wdata = bus_req.wdata;

    ////////////////////////////////////////////////////////////////////////////
    // Reads
    ////////////////////////////////////////////////////////////////////////////

    assign rd_out_of_range = (bus_req.addr >= NUM_REGS);

    always_ff @(posedge clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            rd_pending <= 1'b0;
            rd_error   <= 1'b0;
        end else begin
            rd_pending <= bus_req.rd;
            rd_error   <= bus_req.rd && rd_out_of_range;
        end
    end

    // Address travels with the read, only meaningful while rd_pending
    always_ff @(posedge clk_ifc) begin
        rd_addr <= bus_req.addr;
    end

endmodule

/* port_stats_bank.sv */
////////////////////////////////////////////////////////////////////////////
// Per-port control, status and counter snapshots
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module port_stats_bank #(
    parameter int NUM_PORTS = 8
) (
    input  logic                   clk_ifc,
    input  logic                   peripheral_sresetn_core,

    // From the decode stage
    input  logic                   wr_enable_con,
    input  logic                   wr_counter_con,
    input  reg_map_pkg::reg_data_t wdata,

    // Traffic path
    input  port_stats_pkg::port_counts_t [NUM_PORTS-1:0] port_counts,
    input  logic [NUM_PORTS-1:0]   ports_connected,
    input  logic [NUM_PORTS-1:0]   buf_full_drop,
    output logic [NUM_PORTS-1:0]   ports_enable,

    // Register contents for readback
    output reg_map_pkg::reg_data_t enable_con,
    output reg_map_pkg::reg_data_t counter_con,
    output reg_map_pkg::reg_data_t enable_stat,
    output port_stats_pkg::count_t
        [NUM_PORTS-1:0][reg_map_pkg::COUNTER_SLOTS_PER_PORT-1:0] snapshots
);

    logic [NUM_PORTS-1:0] enable_q;
    logic [NUM_PORTS-1:0] counter_q;
    logic [NUM_PORTS-1:0] connected_q;

    logic [NUM_PORTS-1:0] sample_req;
    logic [NUM_PORTS-1:0] sample_req_d;
    logic [NUM_PORTS-1:0] sample_edge;

    logic [NUM_PORTS-1:0] drop_d;
    logic [NUM_PORTS-1:0] drop_rise;

    ////////////////////////////////////////////////////////////////////////////
    // Control and status registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            // All ports come up enabled
            enable_q     <= '1;
            counter_q    <= '0;
            connected_q  <= '0;
            sample_req   <= '0;
            sample_req_d <= '0;
            drop_d       <= '0;
        end else begin
            if (wr_enable_con) begin
                enable_q <= wdata[NUM_PORTS-1:0];
            end
            if (wr_counter_con) begin
                counter_q <= wdata[NUM_PORTS-1:0];
            end
            connected_q  <= ports_connected;
            sample_req   <= counter_q;
            sample_req_d <= sample_req;
            drop_d       <= buf_full_drop;
        end
    end

    assign sample_edge = sample_req & ~sample_req_d;
    assign drop_rise   = buf_full_drop & ~drop_d;

    assign ports_enable = enable_q;

    // Unused upper bits read as zero
    assign enable_con  = reg_map_pkg::reg_data_t'(enable_q);
    assign counter_con = reg_map_pkg::reg_data_t'(counter_q);
    assign enable_stat = reg_map_pkg::reg_data_t'(connected_q);

    ////////////////////////////////////////////////////////////////////////////
    // Drop counters and snapshots
    ////////////////////////////////////////////////////////////////////////////

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        port_stats_pkg::count_t drop_cnt;
        port_stats_pkg::count_t [reg_map_pkg::COUNTER_SLOTS_PER_PORT-1:0] snap_q;

        always_ff @(posedge clk_ifc) begin
            if (!peripheral_sresetn_core) begin
                drop_cnt <= '0;
                snap_q   <= '0;
            end else if (sample_edge[p]) begin
                snap_q[port_stats_pkg::SLOT_PKT]   <= port_counts[p].pkt;
                snap_q[port_stats_pkg::SLOT_BYTES] <= port_counts[p].bytes;
                snap_q[port_stats_pkg::SLOT_ERR]   <= port_counts[p].err;
                snap_q[port_stats_pkg::SLOT_DROP]  <= drop_cnt;
                // An edge in the snapshot cycle belongs to the next interval
                drop_cnt <= port_stats_pkg::count_t'(drop_rise[p]);
            end else if (drop_rise[p]) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
        end

        assign snapshots[p] = snap_q;
    end

endmodule

/* reg_readback.sv */
////////////////////////////////////////////////////////////////////////////
// Read data select and response
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reg_readback #(
    parameter int NUM_PORTS = 8
) (
    input  logic                   clk_ifc,
    input  logic                   peripheral_sresetn_core,

    input  logic                   rd_pending,
    input  logic                   rd_error,
    input  reg_map_pkg::reg_addr_t rd_addr,

    input  reg_map_pkg::reg_data_t enable_con,
    input  reg_map_pkg::reg_data_t counter_con,
    input  reg_map_pkg::reg_data_t enable_stat,
    input  port_stats_pkg::count_t
        [NUM_PORTS-1:0][reg_map_pkg::COUNTER_SLOTS_PER_PORT-1:0] snapshots,

    output reg_map_pkg::reg_rsp_t  bus_rsp
);

    localparam reg_map_pkg::reg_data_t NUM_REGS = reg_map_pkg::reg_data_t'(
        reg_map_pkg::ADDR_COUNTERS_START + reg_map_pkg::COUNTER_SLOTS_PER_PORT * NUM_PORTS);

    reg_map_pkg::reg_addr_t        cnt_offset;
    logic [5:0]                    port_idx;
    port_stats_pkg::counter_slot_e slot;
    reg_map_pkg::reg_data_t        sel_data;

    logic                   rsp_valid_q;
    logic                   rsp_error_q;
    reg_map_pkg::reg_data_t rsp_data_q;

    // Counter block address split into port and slot
    assign cnt_offset = rd_addr - reg_map_pkg::ADDR_COUNTERS_START;
    assign port_idx   = cnt_offset[7:2];
    assign slot       = port_stats_pkg::counter_slot_e'(cnt_offset[1:0]);

    always_comb begin
        sel_data = '0;
        case (rd_addr)
            reg_map_pkg::ADDR_VERSION_ID:       sel_data = reg_map_pkg::MODULE_VERSION_ID;
            reg_map_pkg::ADDR_NUM_REGS:         sel_data = NUM_REGS;
            reg_map_pkg::ADDR_PORT_ENABLE_CON:  sel_data = enable_con;
            reg_map_pkg::ADDR_PORT_ENABLE_STAT: sel_data = enable_stat;
            reg_map_pkg::ADDR_COUNTER_CON:      sel_data = counter_con;
            default: begin
                if (port_idx < NUM_PORTS) begin
                    sel_data = snapshots[port_idx][slot];
                end
            end
        endcase
    end

    always_ff @(posedge clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            rsp_valid_q <= 1'b0;
            rsp_error_q <= 1'b0;
        end else begin
            rsp_valid_q <= rd_pending;
            rsp_error_q <= rd_pending && rd_error;
        end
    end

    // Unmapped reads return zero
    always_ff @(posedge clk_ifc) begin
        rsp_data_q <= rd_error ? '0 : sel_data;
    end

    assign bus_rsp = '{rd_valid: rsp_valid_q, rd_error: rsp_error_q, rd_data: rsp_data_q};

endmodule

/* router_stats_regs.sv */
////////////////////////////////////////////////////////////////////////////
// Router port statistics registers
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module router_stats_regs #(
    parameter int NUM_PORTS = 8
) (
    input  logic                  clk_ifc,
    input  logic                  peripheral_sresetn_core,

    // Register port
    input  reg_map_pkg::reg_req_t bus_req,
    output reg_map_pkg::reg_rsp_t bus_rsp,

    // Traffic path
    input  port_stats_pkg::port_counts_t [NUM_PORTS-1:0] port_counts,
    input  logic [NUM_PORTS-1:0]  ports_connected,
    input  logic [NUM_PORTS-1:0]  buf_full_drop,
    output logic [NUM_PORTS-1:0]  ports_enable
);

    logic                   wr_enable_con;
    logic                   wr_counter_con;
    reg_map_pkg::reg_data_t wdata;

    logic                   rd_pending;
    logic                   rd_error;
    reg_map_pkg::reg_addr_t rd_addr;

    reg_map_pkg::reg_data_t enable_con;
    reg_map_pkg::reg_data_t counter_con;
    reg_map_pkg::reg_data_t enable_stat;
    port_stats_pkg::count_t
        [NUM_PORTS-1:0][reg_map_pkg::COUNTER_SLOTS_PER_PORT-1:0] snapshots;

    reg_decode #(
        .NUM_PORTS               ( NUM_PORTS               )
    ) u_decode (
        .clk_ifc                 ( clk_ifc                 ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .bus_req                 ( bus_req                 ),
        .wr_enable_con           ( wr_enable_con           ),
        .wr_counter_con          ( wr_counter_con          ),
        .wdata                   ( wdata                   ),
        .rd_pending              ( rd_pending              ),
        .rd_error                ( rd_error                ),
        .rd_addr                 ( rd_addr                 )
    );

    port_stats_bank #(
        .NUM_PORTS               ( NUM_PORTS               )
    ) u_stats (
        .clk_ifc                 ( clk_ifc                 ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .wr_enable_con           ( wr_enable_con           ),
        .wr_counter_con          ( wr_counter_con          ),
        .wdata                   ( wdata                   ),
        .port_counts             ( port_counts             ),
        .ports_connected         ( ports_connected         ),
        .buf_full_drop           ( buf_full_drop           ),
        .ports_enable            ( ports_enable            ),
        .enable_con              ( enable_con              ),
        .counter_con             ( counter_con             ),
        .enable_stat             ( enable_stat             ),
        .snapshots               ( snapshots               )
    );

    reg_readback #(
        .NUM_PORTS               ( NUM_PORTS               )
    ) u_readback (
        .clk_ifc                 ( clk_ifc                 ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .rd_pending              ( rd_pending              ),
        .rd_error                ( rd_error                ),
        .rd_addr                 ( rd_addr                 ),
        .enable_con              ( enable_con              ),
        .counter_con             ( counter_con             ),
        .enable_stat             ( enable_stat             ),
        .snapshots               ( snapshots               ),
        .bus_rsp                 ( bus_rsp                 )
    );

endmodule

/* stats_regs_assertions.sv */
////////////////////////////////////////////////////////////////////////////
// Register port timing assertions
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stats_regs_assertions #(
    parameter int NUM_PORTS = 8
) (
    input logic                  clk_ifc,
    input logic                  peripheral_sresetn_core,
    input reg_map_pkg::reg_req_t bus_req,
    input reg_map_pkg::reg_rsp_t bus_rsp,
    input logic [NUM_PORTS-1:0]  ports_enable
);

    int failures = 0;

    // Every read strobe is answered exactly two cycles later
    a_read_answered: assert property (@(posedge clk_ifc) disable iff (!peripheral_sresetn_core)
        bus_req.rd |-> ##2 bus_rsp.rd_valid)
    else begin
        failures++;
        $error("read strobe not answered two cycles later");
    end

    a_no_spurious_valid: assert property (@(posedge clk_ifc) disable iff (!peripheral_sresetn_core)
        bus_rsp.rd_valid |-> $past(bus_req.rd, 2))
    else begin
        failures++;
        $error("read response without a read strobe two cycles earlier");
    end

    // First cycle out of reset
    a_reset_state: assert property (@(posedge clk_ifc)
        $rose(peripheral_sresetn_core) |-> (ports_enable == '1) && !bus_rsp.rd_valid)
    else begin
        failures++;
        $error("wrong port enables or read response after reset");
    end

endmodule

bind router_stats_regs stats_regs_assertions #(
    .NUM_PORTS               ( NUM_PORTS               )
) u_assertions (
    .clk_ifc                 ( clk_ifc                 ),
    .peripheral_sresetn_core ( peripheral_sresetn_core ),
    .bus_req                 ( bus_req                 ),
    .bus_rsp                 ( bus_rsp                 ),
    .ports_enable            ( ports_enable            )
);

/* stats_checker.sv */
////////////////////////////////////////////////////////////////////////////
// Register file model and response checker
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stats_checker #(
    parameter int NUM_PORTS = 8
) (
    input  logic                  clk_ifc,
    input  logic                  peripheral_sresetn_core,
    input  reg_map_pkg::reg_req_t bus_req,
    input  reg_map_pkg::reg_rsp_t bus_rsp,
    input  port_stats_pkg::port_counts_t [NUM_PORTS-1:0] port_counts,
    input  logic [NUM_PORTS-1:0]  ports_connected,
    input  logic [NUM_PORTS-1:0]  buf_full_drop,
    input  logic [NUM_PORTS-1:0]  ports_enable,
    output int                    pending_reads,
    output int                    checks_done,
    output int                    test_errors,
    output int                    total_errors
);

    localparam int NUM_REGS = 5 + 4 * NUM_PORTS;

    string                test_name = "idle";
    logic [NUM_PORTS-1:0] enable_m;
    logic [NUM_PORTS-1:0] counter_m;
    logic [NUM_PORTS-1:0] connected_m;
    logic [NUM_PORTS-1:0] req_m;
    logic [NUM_PORTS-1:0] req_d_m;
    logic [NUM_PORTS-1:0] drop_d_m;
    logic [31:0]          snap_m [NUM_PORTS][4];
    logic [31:0]          drop_m [NUM_PORTS];
    // Address, error flag and data of each read in flight
    logic [40:0]          exp_q [$];

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic count_error();
        test_errors++;
        total_errors++;
    endtask

    function automatic logic [32:0] expected_read(input logic [7:0] addr);
        int off;
        off = int'(addr) - 5;
        if (addr >= NUM_REGS) begin
            return {1'b1, 32'd0};
        end
        case (addr)
            reg_map_pkg::ADDR_VERSION_ID:       return {1'b0, 32'h0100_000a};
            reg_map_pkg::ADDR_NUM_REGS:         return {1'b0, 32'(NUM_REGS)};
            reg_map_pkg::ADDR_PORT_ENABLE_CON:  return {1'b0, 32'(enable_m)};
            reg_map_pkg::ADDR_PORT_ENABLE_STAT: return {1'b0, 32'(connected_m)};
            reg_map_pkg::ADDR_COUNTER_CON:      return {1'b0, 32'(counter_m)};
            default:                            return {1'b0, snap_m[off / 4][off % 4]};
        endcase
    endfunction

    always @(posedge clk_ifc) begin : model_step
        logic [NUM_PORTS-1:0] sample_edge;
        logic [NUM_PORTS-1:0] drop_rise;
        logic [40:0]          exp;
        if (!peripheral_sresetn_core) begin
            enable_m    = '1;
            counter_m   = '0;
            connected_m = '0;
            req_m       = '0;
            req_d_m     = '0;
            drop_d_m    = '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                drop_m[p] = '0;
                for (int s = 0; s < 4; s++) begin
                    snap_m[p][s] = '0;
                end
            end
            exp_q.delete();
        end else begin
            if (bus_rsp.rd_valid && exp_q.size() == 0) begin
                $display("%s: read response arrived with no read outstanding", test_name);
                count_error();
            end else if (bus_rsp.rd_valid) begin
                exp = exp_q.pop_front();
                checks_done++;
                if ({bus_rsp.rd_error, bus_rsp.rd_data} !== exp[32:0]) begin
                    $display("ERR %s addr %0d: expected %0b/%08h actual %0b/%08h", test_name,
                             exp[40:33], exp[32], exp[31:0], bus_rsp.rd_error, bus_rsp.rd_data);
                    count_error();
                end
            end
            if (ports_enable !== enable_m) begin
                $display("ERR %s ports_enable: expected %h actual %h", test_name,
                         enable_m, ports_enable);
                count_error();
            end

            // Snapshot two edges after the counter control write
            sample_edge = req_m & ~req_d_m;
            drop_rise   = buf_full_drop & ~drop_d_m;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (sample_edge[p]) begin
                    snap_m[p][0] = port_counts[p].pkt;
                    snap_m[p][1] = port_counts[p].bytes;
                    snap_m[p][2] = port_counts[p].err;
                    snap_m[p][3] = drop_m[p];
                    drop_m[p]    = drop_rise[p] ? 32'd1 : 32'd0;
                end else if (drop_rise[p]) begin
                    drop_m[p] = drop_m[p] + 32'd1;
                end
            end
            req_d_m     = req_m;
            req_m       = counter_m;
            drop_d_m    = buf_full_drop;
            connected_m = ports_connected;

            if (bus_req.wr && bus_req.addr == reg_map_pkg::ADDR_PORT_ENABLE_CON) begin
                enable_m = bus_req.wdata[NUM_PORTS-1:0];
            end
            if (bus_req.wr && bus_req.addr == reg_map_pkg::ADDR_COUNTER_CON) begin
                counter_m = bus_req.wdata[NUM_PORTS-1:0];
            end
            if (bus_req.rd) begin
                exp_q.push_back({bus_req.addr, expected_read(bus_req.addr)});
            end
        end
        pending_reads = exp_q.size();
    end

endmodule

/* router_stats_regs_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Router statistics registers testbench
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module router_stats_regs_tb;

    localparam int NUM_PORTS = 8;
    localparam int NUM_REGS  = 5 + 4 * NUM_PORTS;

    logic                  clk_ifc;
    logic                  peripheral_sresetn_core;
    reg_map_pkg::reg_req_t bus_req;
    reg_map_pkg::reg_rsp_t bus_rsp;
    port_stats_pkg::port_counts_t [NUM_PORTS-1:0] port_counts;
    logic [NUM_PORTS-1:0]  ports_connected;
    logic [NUM_PORTS-1:0]  buf_full_drop;
    logic [NUM_PORTS-1:0]  ports_enable;

    int          pending_reads;
    int          checks_done;
    int          test_errors;
    int          total_errors;
    int          timeouts;
    int          tests_run;
    string       cur_test;
    logic [31:0] lfsr_state;

    router_stats_regs #(
        .NUM_PORTS               ( NUM_PORTS               )
    ) u_dut (
        .clk_ifc                 ( clk_ifc                 ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .bus_req                 ( bus_req                 ),
        .bus_rsp                 ( bus_rsp                 ),
        .port_counts             ( port_counts             ),
        .ports_connected         ( ports_connected         ),
        .buf_full_drop           ( buf_full_drop           ),
        .ports_enable            ( ports_enable            )
    );

    stats_checker #(
        .NUM_PORTS               ( NUM_PORTS               )
    ) u_checker (
        .clk_ifc                 ( clk_ifc                 ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .bus_req                 ( bus_req                 ),
        .bus_rsp                 ( bus_rsp                 ),
        .port_counts             ( port_counts             ),
        .ports_connected         ( ports_connected         ),
        .buf_full_drop           ( buf_full_drop           ),
        .ports_enable            ( ports_enable            ),
        .pending_reads           ( pending_reads           ),
        .checks_done             ( checks_done             ),
        .test_errors             ( test_errors             ),
        .total_errors            ( total_errors            )
    );

    initial begin
        clk_ifc = 1'b0;
        forever #20 clk_ifc = ~clk_ifc;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic bus_write(input reg_map_pkg::reg_addr_t addr,
                             input reg_map_pkg::reg_data_t data);
        @(posedge clk_ifc);
        #2;
        bus_req = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
        @(posedge clk_ifc);
        #2;
        bus_req = '0;
    endtask

    task automatic wait_reads_done();
        int cycles;
        cycles = 0;
        while (pending_reads != 0 && cycles < 16) begin
            @(posedge clk_ifc);
            #2;
            cycles++;
        end
        if (pending_reads != 0) begin
            $display("%s: timed out waiting for read responses", cur_test);
            timeouts++;
        end
    endtask

    // Back-to-back read strobes over an address range
    task automatic read_range(input int first, input int last);
        for (int a = first; a <= last; a++) begin
            @(posedge clk_ifc);
            #2;
            bus_req = '{wr: 1'b0, rd: 1'b1, addr: reg_map_pkg::reg_addr_t'(a), wdata: '0};
        end
        @(posedge clk_ifc);
        #2;
        bus_req = '0;
        wait_reads_done();
    endtask

    task automatic sample_ports(input reg_map_pkg::reg_data_t mask);
        bus_write(reg_map_pkg::ADDR_COUNTER_CON, '0);
        bus_write(reg_map_pkg::ADDR_COUNTER_CON, mask);
        repeat (2) @(posedge clk_ifc);
    endtask

    task automatic pulse_drops(input int port, input int count);
        for (int k = 0; k < count; k++) begin
            @(posedge clk_ifc);
            #2;
            buf_full_drop[port] = 1'b1;
            @(posedge clk_ifc);
            #2;
            buf_full_drop[port] = 1'b0;
            repeat (rand_bits(2)) @(posedge clk_ifc);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        u_checker.start_test(name);
    endtask

    task automatic end_test();
        tests_run++;
        $display("%s: %0d errors", cur_test, test_errors);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        peripheral_sresetn_core = 1'b0;
        bus_req                 = '0;
        port_counts             = '0;
        ports_connected         = '0;
        buf_full_drop           = '0;
        lfsr_state              = 32'hd6505fe0;
        timeouts                = 0;
        tests_run               = 0;
        repeat (4) @(posedge clk_ifc);
        #2;
        peripheral_sresetn_core = 1'b1;

        begin_test("reset_values");
        read_range(0, NUM_REGS - 1);
        end_test();

        begin_test("enable_control");
        repeat (6) begin
            bus_write(reg_map_pkg::ADDR_PORT_ENABLE_CON, rand_bits(32));
            read_range(2, 2);
        end
        // Read-only and counter addresses ignore writes
        bus_write(reg_map_pkg::ADDR_VERSION_ID, rand_bits(32));
        bus_write(reg_map_pkg::ADDR_PORT_ENABLE_STAT, rand_bits(32));
        bus_write(reg_map_pkg::ADDR_COUNTERS_START, rand_bits(32));
        read_range(0, 5);
        read_range(NUM_REGS, NUM_REGS + 2);
        read_range(255, 255);
        end_test();

        begin_test("connected_status");
        repeat (4) begin
            ports_connected = NUM_PORTS'(rand_bits(NUM_PORTS));
            read_range(3, 3);
        end
        end_test();

        begin_test("snapshots");
        repeat (3) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                port_counts[p] = {rand_bits(32), rand_bits(32), rand_bits(32)};
            end
            sample_ports(rand_bits(NUM_PORTS));
            read_range(5, NUM_REGS - 1);
        end
        end_test();

        begin_test("drop_counting");
        for (int p = 0; p < NUM_PORTS; p++) begin
            pulse_drops(p, rand_bits(3));
        end
        sample_ports('1);
        read_range(5, NUM_REGS - 1);
        sample_ports('1);
        read_range(5, NUM_REGS - 1);
        end_test();

        $display("tests %0d  checks %0d  errors %0d  timeouts %0d  assertion failures %0d",
                 tests_run, checks_done, total_errors, timeouts, u_dut.u_assertions.failures);
        if (total_errors == 0 && timeouts == 0 && u_dut.u_assertions.failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* files.f */
reg_map_pkg.sv
port_stats_pkg.sv
reg_decode.sv
port_stats_bank.sv
reg_readback.sv
router_stats_regs.sv
stats_regs_assertions.sv
stats_checker.sv
router_stats_regs_tb.sv

/* Bender.yml */
package:
  name: router_stats_regs

sources:
  - files:
      - reg_map_pkg.sv
      - port_stats_pkg.sv
      - reg_decode.sv
      - port_stats_bank.sv
      - reg_readback.sv
      - router_stats_regs.sv
  - target: test
    files:
      - stats_regs_assertions.sv
      - stats_checker.sv
      - router_stats_regs_tb.sv
